// ==== Makefile ====
# Verilator build and run for the AXI SRAM slave testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = axi_sram_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/axi_sram_pkg.sv ====
// AXI SRAM shared widths, response and burst codes, burst address helpers
`default_nettype none

package axi_sram_pkg;

  localparam int ID_WIDTH   = 4;
  localparam int LEN_WIDTH  = 8;
  // Wide enough for any address plus a full burst span
  localparam int CALC_WIDTH = 64;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_t;

  // Address of the following beat; WRAP steps like INCR, it is rejected elsewhere
  function automatic logic [CALC_WIDTH-1:0] next_beat_addr(
    input logic [CALC_WIDTH-1:0] addr,
    input logic [2:0]            size,
    input burst_t                burst
  );
    logic [CALC_WIDTH-1:0] step;
    step = CALC_WIDTH'(1) << size;
    if (burst == BURST_FIXED) begin
      return addr;
    end
    return addr + step;
  endfunction

  // True when every byte the burst touches lies below mem_bytes
  function automatic logic burst_in_range(
    input logic [CALC_WIDTH-1:0] start_addr,
    input logic [LEN_WIDTH-1:0]  len,
    input logic [2:0]            size,
    input burst_t                burst,
    input logic [CALC_WIDTH-1:0] mem_bytes
  );
    logic [CALC_WIDTH-1:0] span;
    if (burst == BURST_FIXED) begin
      span = CALC_WIDTH'(1) << size;
    end else begin
      span = (CALC_WIDTH'(len) + 1) << size;
    end
    return (start_addr < mem_bytes) && (span <= mem_bytes - start_addr);
  endfunction

endpackage

`default_nettype wire

// ==== hw/axi_sram_read_ctrl.sv ====
// AXI4 read engine: AR/R state machine, burst stepping, range check, beat output register
`timescale 1ns/1ps
`default_nettype none

module axi_sram_read_ctrl #(
  parameter int DATA_WIDTH     = 64,
  parameter int ADDR_WIDTH     = 32,
  parameter int MEM_WORDS_LOG2 = 10
) (
  input  logic                               i_aclk,
  input  logic                               i_reset,

  // Read address channel
  input  logic [axi_sram_pkg::ID_WIDTH-1:0]  i_arid,
  input  logic [ADDR_WIDTH-1:0]              i_araddr,
  input  logic [axi_sram_pkg::LEN_WIDTH-1:0] i_arlen,
  input  logic [2:0]                         i_arsize,
  input  logic [1:0]                         i_arburst,
  input  logic                               i_arvalid,
  output logic                               o_arready,

  // Read data channel
  output logic [axi_sram_pkg::ID_WIDTH-1:0]  o_rid,
  output logic [DATA_WIDTH-1:0]              o_rdata,
  output logic [1:0]                         o_rresp,
  output logic                               o_rlast,
  output logic                               o_rvalid,
  input  logic                               i_rready,

  // Bank read port
  output logic                               o_mem_ren,
  output logic [MEM_WORDS_LOG2-1:0]          o_mem_raddr,
  input  logic [DATA_WIDTH-1:0]              i_mem_rdata
);

  import axi_sram_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int BYTE_OFFS  = $clog2(STRB_WIDTH);
  localparam logic [CALC_WIDTH-1:0] MEM_BYTES = CALC_WIDTH'(STRB_WIDTH) << MEM_WORDS_LOG2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_SEND
  } state_t;

  state_t                 state;
  logic [ID_WIDTH-1:0]    id_q;
  logic [ADDR_WIDTH-1:0]  addr_q;
  logic [LEN_WIDTH-1:0]   len_q;
  logic [2:0]             size_q;
  burst_t                 burst_q;
  logic                   err_q;
  logic [LEN_WIDTH-1:0]   beat_cnt;
  logic [DATA_WIDTH-1:0]  rdata_q;
  logic                   rlast_q;
  logic                   ar_fire;
  logic                   r_fire;
  logic                   ar_err;
  logic [ADDR_WIDTH-1:0]  addr_next;

  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  assign ar_err = (i_arburst == BURST_WRAP) ||
                  !burst_in_range(CALC_WIDTH'(i_araddr), i_arlen, i_arsize,
                                  burst_t'(i_arburst), MEM_BYTES);

  assign addr_next = ADDR_WIDTH'(next_beat_addr(CALC_WIDTH'(addr_q), size_q, burst_q));

  // Bank is read on the handshake edge, data is ready during FETCH
  assign o_mem_ren   = ar_fire | (r_fire & ~rlast_q);
  assign o_mem_raddr = ar_fire ? i_araddr[BYTE_OFFS +: MEM_WORDS_LOG2]
                               : addr_next[BYTE_OFFS +: MEM_WORDS_LOG2];

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      state    <= ST_IDLE;
      err_q    <= 1'b0;
      beat_cnt <= '0;
      rlast_q  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (ar_fire) begin
            state    <= ST_FETCH;
            err_q    <= ar_err;
            beat_cnt <= '0;
          end
        end
        ST_FETCH: begin
          state   <= ST_SEND;
          rlast_q <= (beat_cnt == len_q);
        end
        ST_SEND: begin
          if (r_fire) begin
            rlast_q  <= 1'b0;
            beat_cnt <= beat_cnt + 1'b1;
            state    <= rlast_q ? ST_IDLE : ST_FETCH;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request fields and beat data
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      id_q    <= i_arid;
      addr_q  <= i_araddr;
      len_q   <= i_arlen;
      size_q  <= i_arsize;
      burst_q <= burst_t'(i_arburst);
    end else if (r_fire) begin
      addr_q <= addr_next;
    end
    if (state == ST_FETCH) begin
      // Failed bursts return zero data
      rdata_q <= err_q ? '0 : i_mem_rdata;
    end
  end

  assign o_arready = (state == ST_IDLE);
  assign o_rvalid  = (state == ST_SEND);
  assign o_rid     = id_q;
  assign o_rdata   = rdata_q;
  assign o_rlast   = rlast_q;
  assign o_rresp   = err_q ? RESP_SLVERR : RESP_OKAY;

  // ----------------------------------------------------------------------
  // Protocol checks
  // ----------------------------------------------------------------------
  a_r_stall_stable: assert property (@(posedge i_aclk) disable iff (i_reset)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rid) &&
                              $stable(o_rlast) && $stable(o_rresp));

  a_rlast_with_rvalid: assert property (@(posedge i_aclk) disable iff (i_reset)
    o_rlast |-> o_rvalid);

endmodule

`default_nettype wire

// ==== hw/axi_sram_top.sv ====
// AXI4 SRAM slave top: write engine, read engine and word bank
`timescale 1ns/1ps
`default_nettype none

module axi_sram_top #(
  parameter int  DATA_WIDTH     = 64,
  parameter int  ADDR_WIDTH     = 32,
  parameter int  MEM_WORDS_LOG2 = 10,
  localparam int STRB_WIDTH     = DATA_WIDTH / 8
) (
  input  logic                               i_aclk,
  input  logic                               i_reset,

  // Write address channel
  input  logic [axi_sram_pkg::ID_WIDTH-1:0]  i_awid,
  input  logic [ADDR_WIDTH-1:0]              i_awaddr,
  input  logic [axi_sram_pkg::LEN_WIDTH-1:0] i_awlen,
  input  logic [2:0]                         i_awsize,
  input  logic [1:0]                         i_awburst,
  input  logic                               i_awlock,
  input  logic [3:0]                         i_awcache,
  input  logic [2:0]                         i_awprot,
  input  logic                               i_awvalid,
  output logic                               o_awready,

  // Write data channel
  input  logic [DATA_WIDTH-1:0]              i_wdata,
  input  logic [STRB_WIDTH-1:0]              i_wstrb,
  input  logic                               i_wlast,
  input  logic                               i_wvalid,
  output logic                               o_wready,

  // Write response channel
  output logic [axi_sram_pkg::ID_WIDTH-1:0]  o_bid,
  output logic [1:0]                         o_bresp,
  output logic                               o_bvalid,
  input  logic                               i_bready,

  // Read address channel
  input  logic [axi_sram_pkg::ID_WIDTH-1:0]  i_arid,
  input  logic [ADDR_WIDTH-1:0]              i_araddr,
  input  logic [axi_sram_pkg::LEN_WIDTH-1:0] i_arlen,
  input  logic [2:0]                         i_arsize,
  input  logic [1:0]                         i_arburst,
  input  logic                               i_arlock,
  input  logic [3:0]                         i_arcache,
  input  logic [2:0]                         i_arprot,
  input  logic                               i_arvalid,
  output logic                               o_arready,

  // Read data channel
  output logic [axi_sram_pkg::ID_WIDTH-1:0]  o_rid,
  output logic [DATA_WIDTH-1:0]              o_rdata,
  output logic [1:0]                         o_rresp,
  output logic                               o_rlast,
  output logic                               o_rvalid,
  input  logic                               i_rready
);

  // Lock, cache and prot are accepted and have no effect on this memory

  logic                      mem_wen;
  logic [MEM_WORDS_LOG2-1:0] mem_waddr;
  logic [DATA_WIDTH-1:0]     mem_wdata;
  logic [STRB_WIDTH-1:0]     mem_wstrb;
  logic                      mem_ren;
  logic [MEM_WORDS_LOG2-1:0] mem_raddr;
  logic [DATA_WIDTH-1:0]     mem_rdata;

  axi_sram_write_ctrl #(
    .DATA_WIDTH     (DATA_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
  ) write_ctrl_i (
    .i_aclk      (i_aclk),
    .i_reset     (i_reset),
    .i_awid      (i_awid),
    .i_awaddr    (i_awaddr),
    .i_awlen     (i_awlen),
    .i_awsize    (i_awsize),
    .i_awburst   (i_awburst),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wlast     (i_wlast),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .o_bid       (o_bid),
    .o_bresp     (o_bresp),
    .o_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .o_mem_wen   (mem_wen),
    .o_mem_waddr (mem_waddr),
    .o_mem_wdata (mem_wdata),
    .o_mem_wstrb (mem_wstrb)
  );

  axi_sram_read_ctrl #(
    .DATA_WIDTH     (DATA_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
  ) read_ctrl_i (
    .i_aclk      (i_aclk),
    .i_reset     (i_reset),
    .i_arid      (i_arid),
    .i_araddr    (i_araddr),
    .i_arlen     (i_arlen),
    .i_arsize    (i_arsize),
    .i_arburst   (i_arburst),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .o_rid       (o_rid),
    .o_rdata     (o_rdata),
    .o_rresp     (o_rresp),
    .o_rlast     (o_rlast),
    .o_rvalid    (o_rvalid),
    .i_rready    (i_rready),
    .o_mem_ren   (mem_ren),
    .o_mem_raddr (mem_raddr),
    .i_mem_rdata (mem_rdata)
  );

  sram_bank #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
  ) bank_i (
    .i_aclk  (i_aclk),
    .i_wen   (mem_wen),
    .i_waddr (mem_waddr),
    .i_wdata (mem_wdata),
    .i_wstrb (mem_wstrb),
    .i_ren   (mem_ren),
    .i_raddr (mem_raddr),
    .o_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== hw/axi_sram_write_ctrl.sv ====
// AXI4 write engine: AW/W/B state machine, burst stepping, range check, B response
`timescale 1ns/1ps
`default_nettype none

module axi_sram_write_ctrl #(
  parameter int  DATA_WIDTH     = 64,
  parameter int  ADDR_WIDTH     = 32,
  parameter int  MEM_WORDS_LOG2 = 10,
  localparam int STRB_WIDTH     = DATA_WIDTH / 8
) (
  input  logic                               i_aclk,
  input  logic                               i_reset,

  // Write address channel
  input  logic [axi_sram_pkg::ID_WIDTH-1:0]  i_awid,
  input  logic [ADDR_WIDTH-1:0]              i_awaddr,
  input  logic [axi_sram_pkg::LEN_WIDTH-1:0] i_awlen,
  input  logic [2:0]                         i_awsize,
  input  logic [1:0]                         i_awburst,
  input  logic                               i_awvalid,
  output logic                               o_awready,

  // Write data channel
  input  logic [DATA_WIDTH-1:0]              i_wdata,
  input  logic [STRB_WIDTH-1:0]              i_wstrb,
  input  logic                               i_wlast,
  input  logic                               i_wvalid,
  output logic                               o_wready,

  // Write response channel
  output logic [axi_sram_pkg::ID_WIDTH-1:0]  o_bid,
  output logic [1:0]                         o_bresp,
  output logic                               o_bvalid,
  input  logic                               i_bready,

  // Bank write port
  output logic                               o_mem_wen,
  output logic [MEM_WORDS_LOG2-1:0]          o_mem_waddr,
  output logic [DATA_WIDTH-1:0]              o_mem_wdata,
  output logic [STRB_WIDTH-1:0]              o_mem_wstrb
);

  import axi_sram_pkg::*;

  localparam int BYTE_OFFS = $clog2(STRB_WIDTH);
  localparam logic [CALC_WIDTH-1:0] MEM_BYTES = CALC_WIDTH'(STRB_WIDTH) << MEM_WORDS_LOG2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_RESP
  } state_t;

  state_t                 state;
  logic [ID_WIDTH-1:0]    id_q;
  logic [ADDR_WIDTH-1:0]  addr_q;
  logic [LEN_WIDTH-1:0]   len_q;
  logic [2:0]             size_q;
  burst_t                 burst_q;
  logic                   err_q;
  logic [LEN_WIDTH-1:0]   beat_cnt;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   b_fire;
  logic                   aw_err;
  logic [ADDR_WIDTH-1:0]  addr_next;

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;

  // WRAP is not supported, so it fails the same way as an overrun
  assign aw_err = (i_awburst == BURST_WRAP) ||
                  !burst_in_range(CALC_WIDTH'(i_awaddr), i_awlen, i_awsize,
                                  burst_t'(i_awburst), MEM_BYTES);

  assign addr_next = ADDR_WIDTH'(next_beat_addr(CALC_WIDTH'(addr_q), size_q, burst_q));

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      state    <= ST_IDLE;
      err_q    <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (aw_fire) begin
            state    <= ST_DATA;
            err_q    <= aw_err;
            beat_cnt <= '0;
          end
        end
        ST_DATA: begin
          if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (i_wlast) begin
              state <= ST_RESP;
            end
          end
        end
        ST_RESP: begin
          if (b_fire) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Captured request, address advances per beat
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      id_q    <= i_awid;
      addr_q  <= i_awaddr;
      len_q   <= i_awlen;
      size_q  <= i_awsize;
      burst_q <= burst_t'(i_awburst);
    end else if (w_fire) begin
      addr_q <= addr_next;
    end
  end

  assign o_awready = (state == ST_IDLE);
  assign o_wready  = (state == ST_DATA);
  assign o_bvalid  = (state == ST_RESP);
  assign o_bid     = id_q;
  assign o_bresp   = err_q ? RESP_SLVERR : RESP_OKAY;

  // Beat lands in the bank on the handshake edge
  assign o_mem_wen   = w_fire & ~err_q;
  assign o_mem_waddr = addr_q[BYTE_OFFS +: MEM_WORDS_LOG2];
  assign o_mem_wdata = i_wdata;
  assign o_mem_wstrb = i_wstrb;

  // ----------------------------------------------------------------------
  // Protocol checks
  // ----------------------------------------------------------------------
  a_wlast_on_final_beat: assert property (@(posedge i_aclk) disable iff (i_reset)
    w_fire |-> (i_wlast == (beat_cnt == len_q)));

  a_bvalid_held: assert property (@(posedge i_aclk) disable iff (i_reset)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bid) && $stable(o_bresp));

endmodule

`default_nettype wire

// ==== hw/sram_bank.sv ====
// SRAM word array with byte-strobed write port and registered read port
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
  parameter int  DATA_WIDTH     = 64,
  parameter int  MEM_WORDS_LOG2 = 10,
  localparam int STRB_WIDTH     = DATA_WIDTH / 8
) (
  input  logic                      i_aclk,

  // Write port
  input  logic                      i_wen,
  input  logic [MEM_WORDS_LOG2-1:0] i_waddr,
  input  logic [DATA_WIDTH-1:0]     i_wdata,
  input  logic [STRB_WIDTH-1:0]     i_wstrb,

  // Read port
  input  logic                      i_ren,
  input  logic [MEM_WORDS_LOG2-1:0] i_raddr,
  output logic [DATA_WIDTH-1:0]     o_rdata
);

  localparam int MEM_WORDS = 1 << MEM_WORDS_LOG2;

  logic [DATA_WIDTH-1:0] mem [0:MEM_WORDS-1];

  // ----------------------------------------------------------------------
  // Write port
  // ----------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_wen) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (i_wstrb[b]) begin
          mem[i_waddr][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read port
  // ----------------------------------------------------------------------
  // Same-word read and write in one cycle returns the old word
  always_ff @(posedge i_aclk) begin
    if (i_ren) begin
      o_rdata <= mem[i_raddr];
    end
  end

endmodule

`default_nettype wire

// ==== tests/axi_sram_checker.sv ====
// AXI SRAM checker: channel snooping, byte shadow memory, expected B and R results
`timescale 1ns/1ps
`default_nettype none

module axi_sram_checker #(
  parameter int DATA_WIDTH     = 64,
  parameter int ADDR_WIDTH     = 32,
  parameter int MEM_WORDS_LOG2 = 10
) (
  input  logic                  i_aclk,
  input  logic                  i_reset,
  input  logic [3:0]            i_awid,
  input  logic [ADDR_WIDTH-1:0] i_awaddr,
  input  logic [7:0]            i_awlen,
  input  logic [2:0]            i_awsize,
  input  logic [1:0]            i_awburst,
  input  logic                  i_awvalid,
  input  logic                  i_awready,
  input  logic [DATA_WIDTH-1:0] i_wdata,
  input  logic [DATA_WIDTH/8-1:0] i_wstrb,
  input  logic                  i_wvalid,
  input  logic                  i_wready,
  input  logic [3:0]            i_bid,
  input  logic [1:0]            i_bresp,
  input  logic                  i_bvalid,
  input  logic                  i_bready,
  input  logic [3:0]            i_arid,
  input  logic [ADDR_WIDTH-1:0] i_araddr,
  input  logic [7:0]            i_arlen,
  input  logic [2:0]            i_arsize,
  input  logic [1:0]            i_arburst,
  input  logic                  i_arvalid,
  input  logic                  i_arready,
  input  logic [3:0]            i_rid,
  input  logic [DATA_WIDTH-1:0] i_rdata,
  input  logic [1:0]            i_rresp,
  input  logic                  i_rlast,
  input  logic                  i_rvalid,
  input  logic                  i_rready,
  output int                    o_errors
);

  import axi_sram_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int MEM_BYTES  = STRB_WIDTH << MEM_WORDS_LOG2;

  logic [7:0]            shadow [0:MEM_BYTES-1];
  bit                    written [0:MEM_BYTES-1];
  logic [3:0]            aw_id, ar_id, rid_q;
  logic [63:0]           w_addr, r_addr;
  logic [2:0]            aw_size, ar_size;
  logic [1:0]            aw_burst, ar_burst, rresp_q;
  logic [7:0]            r_len, r_beat;
  logic                  w_ok, r_ok, stall_q, rlast_q, mism;
  logic [DATA_WIDTH-1:0] rdata_q, exp_word;
  int                    base;

  // FIXED holds the address and INCR moves on by one transfer size
  function automatic logic [63:0] step_addr(input logic [63:0] addr, input logic [2:0] size,
                                            input logic [1:0] burst);
    return (burst == BURST_FIXED) ? addr : addr + (64'd1 << size);
  endfunction

  function automatic logic burst_ok(input logic [63:0] addr, input logic [7:0] len,
                                    input logic [2:0] size, input logic [1:0] burst);
    logic [63:0] span;
    span = (burst == BURST_FIXED) ? (64'd1 << size) : ((64'(len) + 64'd1) << size);
    return (burst != BURST_WRAP) && (addr + span <= 64'(MEM_BYTES));
  endfunction

  // Expected word from the shadow bytes at a word-aligned byte index
  function automatic logic [DATA_WIDTH-1:0] expected_word(input int idx);
    logic [DATA_WIDTH-1:0] w;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      w[8*b +: 8] = shadow[idx + b];
    end
    return w;
  endfunction

  task automatic report_error(input string msg);
    o_errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  initial begin
    o_errors = 0;
    stall_q  = 1'b0;
  end

  // ----------------------------------------------------------------------
  // Comparison process on the rising edge
  // ----------------------------------------------------------------------
  always @(posedge i_aclk) begin
    if (!i_reset) begin
      if (i_awvalid && i_awready) begin
        aw_id    = i_awid;
        w_addr   = 64'(i_awaddr);
        aw_size  = i_awsize;
        aw_burst = i_awburst;
        w_ok     = burst_ok(64'(i_awaddr), i_awlen, i_awsize, i_awburst);
      end
      if (i_wvalid && i_wready) begin
        if (w_ok) begin
          base = int'(w_addr[31:0]) & ~(STRB_WIDTH - 1);
          for (int b = 0; b < STRB_WIDTH; b++) begin
            if (i_wstrb[b]) begin
              shadow[base + b]  = i_wdata[8*b +: 8];
              written[base + b] = 1'b1;
            end
          end
        end
        w_addr = step_addr(w_addr, aw_size, aw_burst);
      end
      if (i_bvalid && i_bready) begin
        if (i_bid !== aw_id) begin
          report_error($sformatf("BID %0h, expected %0h", i_bid, aw_id));
        end
        if (i_bresp !== (w_ok ? RESP_OKAY : RESP_SLVERR)) begin
          report_error($sformatf("BRESP %0d for a burst with range ok=%0b", i_bresp, w_ok));
        end
      end
      if (i_arvalid && i_arready) begin
        ar_id    = i_arid;
        r_addr   = 64'(i_araddr);
        r_len    = i_arlen;
        r_beat   = 8'd0;
        ar_size  = i_arsize;
        ar_burst = i_arburst;
        r_ok     = burst_ok(64'(i_araddr), i_arlen, i_arsize, i_arburst);
      end
      if (stall_q && (!i_rvalid || i_rdata !== rdata_q || i_rlast !== rlast_q ||
                      i_rid !== rid_q || i_rresp !== rresp_q)) begin
        report_error("R channel changed while RREADY was low");
      end
      stall_q = i_rvalid && !i_rready;
      rdata_q = i_rdata;
      rlast_q = i_rlast;
      rid_q   = i_rid;
      rresp_q = i_rresp;
      if (i_rvalid && i_rready) begin
        if (i_rid !== ar_id) begin
          report_error($sformatf("RID %0h, expected %0h", i_rid, ar_id));
        end
        if (i_rresp !== (r_ok ? RESP_OKAY : RESP_SLVERR)) begin
          report_error($sformatf("RRESP %0d on beat %0d", i_rresp, r_beat));
        end
        if (i_rlast !== (r_beat == r_len)) begin
          report_error($sformatf("RLAST %0b on beat %0d of %0d", i_rlast, r_beat + 8'd1,
                                 r_len + 8'd1));
        end
        if (!r_ok) begin
          if (i_rdata !== '0) begin
            report_error($sformatf("RDATA %h on a failed burst, expected zero", i_rdata));
          end
        end else begin
          base     = int'(r_addr[31:0]) & ~(STRB_WIDTH - 1);
          exp_word = expected_word(base);
          mism     = 1'b0;
          // Bytes never written have no expected value
          for (int b = 0; b < STRB_WIDTH; b++) begin
            if (written[base + b] && i_rdata[8*b +: 8] !== exp_word[8*b +: 8]) begin
              mism = 1'b1;
            end
          end
          if (mism) begin
            report_error($sformatf("RDATA %h at %h, expected %h", i_rdata, r_addr, exp_word));
          end
        end
        r_addr = step_addr(r_addr, ar_size, ar_burst);
        r_beat = r_beat + 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/axi_sram_tb.sv ====
// AXI SRAM testbench: clock, reset, random source, burst tasks and scenario sequence
`timescale 1ns/1ps
`default_nettype none

module axi_sram_tb;

  import axi_sram_pkg::*;

  localparam int DATA_WIDTH     = 64;
  localparam int ADDR_WIDTH     = 32;
  localparam int MEM_WORDS_LOG2 = 10;
  localparam int MEM_BYTES      = 8 << MEM_WORDS_LOG2;
  localparam int TIMEOUT        = 1000;

  logic        aclk, reset;
  logic [3:0]  awid, arid, bid, rid;
  logic [31:0] awaddr, araddr;
  logic [7:0]  awlen, arlen, wstrb;
  logic [2:0]  awsize, arsize, awprot, arprot;
  logic [1:0]  awburst, arburst, bresp, rresp;
  logic [3:0]  awcache, arcache;
  logic        awlock, arlock, awvalid, awready, arvalid, arready;
  logic [63:0] wdata, rdata;
  logic        wlast, wvalid, wready, bvalid, bready, rlast, rvalid, rready;
  logic [31:0] lcg_state, r;
  logic        use_gaps;
  int          chk_errors, tb_errors, timeouts;

  axi_sram_top #(
    .DATA_WIDTH     (DATA_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
  ) axi_sram_top_i (
    .i_aclk (aclk), .i_reset (reset),
    .i_awid (awid), .i_awaddr (awaddr), .i_awlen (awlen), .i_awsize (awsize),
    .i_awburst (awburst), .i_awlock (awlock), .i_awcache (awcache), .i_awprot (awprot),
    .i_awvalid (awvalid), .o_awready (awready),
    .i_wdata (wdata), .i_wstrb (wstrb), .i_wlast (wlast), .i_wvalid (wvalid),
    .o_wready (wready),
    .o_bid (bid), .o_bresp (bresp), .o_bvalid (bvalid), .i_bready (bready),
    .i_arid (arid), .i_araddr (araddr), .i_arlen (arlen), .i_arsize (arsize),
    .i_arburst (arburst), .i_arlock (arlock), .i_arcache (arcache), .i_arprot (arprot),
    .i_arvalid (arvalid), .o_arready (arready),
    .o_rid (rid), .o_rdata (rdata), .o_rresp (rresp), .o_rlast (rlast),
    .o_rvalid (rvalid), .i_rready (rready)
  );

  axi_sram_checker #(
    .DATA_WIDTH     (DATA_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
  ) checker_i (
    .i_aclk (aclk), .i_reset (reset),
    .i_awid (awid), .i_awaddr (awaddr), .i_awlen (awlen), .i_awsize (awsize),
    .i_awburst (awburst), .i_awvalid (awvalid), .i_awready (awready),
    .i_wdata (wdata), .i_wstrb (wstrb), .i_wvalid (wvalid), .i_wready (wready),
    .i_bid (bid), .i_bresp (bresp), .i_bvalid (bvalid), .i_bready (bready),
    .i_arid (arid), .i_araddr (araddr), .i_arlen (arlen), .i_arsize (arsize),
    .i_arburst (arburst), .i_arvalid (arvalid), .i_arready (arready),
    .i_rid (rid), .i_rdata (rdata), .i_rresp (rresp), .i_rlast (rlast),
    .i_rvalid (rvalid), .i_rready (rready), .o_errors (chk_errors)
  );

  always #2 aclk = ~aclk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic ready_of(input int sel);
    case (sel)
      0:       return awready;
      1:       return wready;
      default: return arready;
    endcase
  endfunction

  // Ready signals are sampled mid-cycle, the handshake lands on the next rising edge
  task automatic wait_high(input int sel, input string what);
    int n;
    n = 0;
    while (!ready_of(sel) && n < TIMEOUT) begin
      @(negedge aclk);
      n++;
    end
    if (!ready_of(sel)) begin
      timeouts++;
      $display("Timeout while waiting for %s", what);
    end
  endtask

  // Drives BREADY or RREADY, with random gaps when enabled, until one transfer
  task automatic take_response(input bit is_read, input string what);
    int   n;
    logic rdy;
    logic vld;
    n = 0;
    do begin
      rdy = !use_gaps || ((next_random() % 3) != 0);
      if (is_read) rready = rdy;
      else bready = rdy;
      vld = is_read ? rvalid : bvalid;
      if (!(vld && rdy)) @(negedge aclk);
      n++;
    end while (!(vld && rdy) && n < TIMEOUT);
    if (!(vld && rdy)) begin
      timeouts++;
      $display("Timeout while waiting for %s", what);
    end
    @(negedge aclk);
    rready = 1'b0;
    bready = 1'b0;
  endtask

  task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
                             input logic [7:0] len, input logic [2:0] size,
                             input logic [1:0] burst, input bit rand_strb);
    @(negedge aclk);
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    awsize  = size;
    awburst = burst;
    awvalid = 1'b1;
    wait_high(0, "AWREADY");
    @(negedge aclk);
    awvalid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      wdata  = {next_random(), next_random()};
      r      = next_random();
      wstrb  = rand_strb ? r[7:0] : 8'hff;
      wlast  = (i == int'(len));
      wvalid = 1'b1;
      wait_high(1, "WREADY");
      @(negedge aclk);
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    take_response(1'b0, "BVALID");
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
                            input logic [7:0] len, input logic [2:0] size,
                            input logic [1:0] burst);
    @(negedge aclk);
    arid    = id;
    araddr  = addr;
    arlen   = len;
    arsize  = size;
    arburst = burst;
    arvalid = 1'b1;
    wait_high(2, "ARREADY");
    @(negedge aclk);
    arvalid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      take_response(1'b1, "RVALID");
    end
  endtask

  // ----------------------------------------------------------------------
  // Scenario sequence
  // ----------------------------------------------------------------------
  initial begin
    aclk = 1'b0;
    reset = 1'b1;
    lcg_state = 32'h042d_ee25;
    use_gaps = 1'b0;
    tb_errors = 0;
    timeouts = 0;
    {awid, awaddr, awlen, awsize, awburst, awlock, awcache, awprot, awvalid} = '0;
    {arid, araddr, arlen, arsize, arburst, arlock, arcache, arprot, arvalid} = '0;
    {wdata, wstrb, wlast, wvalid, bready, rready} = '0;
    repeat (8) @(negedge aclk);
    reset = 1'b0;
    @(negedge aclk);
    if (!(awready && arready && !bvalid && !rvalid && !wready)) begin
      tb_errors++;
      $display("ERR %0t: ready and valid levels after reset are wrong", $time);
    end

    write_burst(4'h1, 32'h40, 8'd0, 3'd3, BURST_INCR, 1'b0);
    read_burst(4'h1, 32'h40, 8'd0, 3'd3, BURST_INCR);

    // Random strobes over known data
    write_burst(4'h2, 32'h100, 8'd3, 3'd3, BURST_INCR, 1'b0);
    write_burst(4'h3, 32'h100, 8'd3, 3'd3, BURST_INCR, 1'b1);
    read_burst(4'h4, 32'h100, 8'd3, 3'd3, BURST_INCR);

    write_burst(4'h5, 32'h200, 8'd7, 3'd3, BURST_INCR, 1'b0);
    read_burst(4'h6, 32'h200, 8'd7, 3'd3, BURST_INCR);
    for (int i = 0; i < 8; i++) begin
      read_burst(4'h7, 32'h200 + 32'(8 * i), 8'd0, 3'd3, BURST_INCR);
    end

    write_burst(4'h8, 32'h300, 8'd5, 3'd3, BURST_FIXED, 1'b1);
    read_burst(4'h9, 32'h300, 8'd0, 3'd3, BURST_INCR);

    // Overrun past the memory end and WRAP bursts
    write_burst(4'ha, 32'(MEM_BYTES - 16), 8'd1, 3'd3, BURST_INCR, 1'b0);
    write_burst(4'hb, 32'(MEM_BYTES - 16), 8'd3, 3'd3, BURST_INCR, 1'b0);
    read_burst(4'hc, 32'(MEM_BYTES - 16), 8'd3, 3'd3, BURST_INCR);
    write_burst(4'hd, 32'h200, 8'd3, 3'd3, BURST_WRAP, 1'b0);
    read_burst(4'he, 32'h200, 8'd3, 3'd3, BURST_WRAP);
    read_burst(4'hf, 32'h200, 8'd7, 3'd3, BURST_INCR);
    read_burst(4'h0, 32'(MEM_BYTES - 16), 8'd1, 3'd3, BURST_INCR);

    use_gaps = 1'b1;
    for (int i = 0; i < 20; i++) begin
      r = next_random();
      write_burst(r[3:0], {21'd0, r[15:8], 3'd0}, {5'd0, r[18:16]}, 3'd3, BURST_INCR, r[19]);
      read_burst(r[23:20], {21'd0, r[15:8], 3'd0}, {5'd0, r[18:16]}, 3'd3, BURST_INCR);
    end

    repeat (4) @(negedge aclk);
    $display("Checker errors: %0d, testbench errors: %0d, timeouts: %0d",
             chk_errors, tb_errors, timeouts);
    if (chk_errors == 0 && tb_errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/axi_sram_pkg.sv
hw/sram_bank.sv
hw/axi_sram_write_ctrl.sv
hw/axi_sram_read_ctrl.sv
hw/axi_sram_top.sv
tests/axi_sram_checker.sv
tests/axi_sram_tb.sv
